//--- Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/reg_file.sv
  - logic/inst_decoder.sv
  - logic/exec_unit.sv
  - logic/load_store_unit.sv
  - logic/core_control.sv
  - logic/rv_core.sv
  - target: test
    files:
      - tests/rv_core_assert.sv
      - tests/rv_core_tb.sv

//--- logic/core_control.sv
/* Sequencer: fetch, decode, execute, then mem for loads and stores.
   The first fetch request comes one cycle after reset is released. */
`timescale 1ns/1ps
`default_nettype none

module core_control #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::xlen-1:0]       imem_rdata,
    input  logic                          is_mem,
    input  logic [rv_pkg::xlen-1:0]       next_pc,
    input  logic                          wb_we,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          imem_req,
    output logic [rv_pkg::xlen-1:0]       pc,
    output logic [rv_pkg::xlen-1:0]       inst,
    output logic                          mem_issue,
    output logic                          reg_write,
    output logic                          retire_valid,
    output logic [rv_pkg::xlen-1:0]       retire_pc,
    output logic                          retire_rd_we,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_rd_data
);
    import rv_pkg::*;

    ctrl_state_t state, state_next;
    logic        run; // low until the first cycle out of reset

    always_comb begin
        case (state)
            st_fetch:   state_next = imem_req ? st_decode : st_fetch;
            st_decode:  state_next = st_execute;
            st_execute: state_next = is_mem ? st_mem : st_fetch;
            default:    state_next = st_fetch; // mem always retires
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
            run   <= 1'b0;
            pc    <= reset_pc;
        end else begin
            state <= state_next;
            run   <= 1'b1;
            if (retire_valid) begin
                pc <= next_pc;
            end
        end
    end

    // imem_rdata is valid in decode
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            inst <= imem_rdata;
        end
    end

    assign imem_req     = run && (state == st_fetch);
    assign mem_issue    = (state == st_execute) && is_mem;
    assign retire_valid = ((state == st_execute) && !is_mem) || (state == st_mem);
    assign reg_write    = retire_valid && wb_we;

    assign retire_pc      = pc;
    assign retire_rd_we   = reg_write;
    assign retire_rd      = rd;
    assign retire_rd_data = wb_data;

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
/* ALU, branch compare, next pc and write-back select, all combinational.
   Misaligned jump targets are not trapped; bit 0 of a JALR target is dropped. */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  rv_pkg::opcode_t               opcode,
    input  logic [2:0]                    funct3,
    input  rv_pkg::alu_op_t               alu_op,
    input  logic [rv_pkg::xlen-1:0]       pc,
    input  logic [rv_pkg::xlen-1:0]       imm,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic [rv_pkg::xlen-1:0]       load_data,
    output logic [rv_pkg::xlen-1:0]       alu_result,
    output logic [rv_pkg::xlen-1:0]       next_pc,
    output logic                          wb_we,
    output logic [rv_pkg::xlen-1:0]       wb_data
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a, op_b, pc_plus4;
    logic            taken, writes_rd;

    assign pc_plus4 = pc + xlen'(4);

    always_comb begin
        op_a = rs1_data;
        op_b = imm;
        case (opcode)
            opc_op:                        op_b = rs2_data;
            opc_lui:                       op_a = '0;
            opc_auipc, opc_jal, opc_branch: op_a = pc; // pc relative targets
            default: ;
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << op_b[4:0];
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> op_b[4:0];
            alu_sra:  alu_result = $signed(op_a) >>> op_b[4:0];
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b; // also address and target generation
        endcase
    end

    always_comb begin
        case (funct3)
            f3_beq:  taken = (rs1_data == rs2_data);
            f3_bne:  taken = (rs1_data != rs2_data);
            f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            f3_bltu: taken = (rs1_data < rs2_data);
            f3_bgeu: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc   = pc_plus4;
        wb_data   = alu_result;
        writes_rd = 1'b0;
        case (opcode)
            opc_op, opc_op_imm, opc_lui, opc_auipc: writes_rd = 1'b1;
            opc_load: begin
                wb_data   = load_data;
                writes_rd = 1'b1;
            end
            opc_jal, opc_jalr: begin
                next_pc   = (opcode == opc_jalr) ? {alu_result[xlen-1:1], 1'b0} : alu_result;
                wb_data   = pc_plus4; // link address
                writes_rd = 1'b1;
            end
            opc_branch: next_pc = taken ? alu_result : pc_plus4;
            default: ; // stores and unknown opcodes write nothing
        endcase
    end

    assign wb_we = writes_rd && (rd != '0);

endmodule

`default_nettype wire

//--- logic/inst_decoder.sv
/* RV32I field split and immediate build; unknown opcodes give a zero immediate
   and the add operation, and are not flagged as memory accesses. */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic [rv_pkg::xlen-1:0]       inst,
    output rv_pkg::opcode_t               opcode,
    output logic [2:0]                    funct3,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::reg_addr_w-1:0] rd,
    output logic [rv_pkg::xlen-1:0]       imm,
    output rv_pkg::alu_op_t               alu_op,
    output logic                          is_mem,
    output logic                          is_store
);
    import rv_pkg::*;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        case (opcode)
            opc_op_imm, opc_load, opc_jalr: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            opc_store: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            opc_branch: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            opc_lui, opc_auipc: begin
                imm = {inst[31:12], 12'h000};
            end
            opc_jal: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

    // inst[30] is funct7[5], which selects sub and sra
    always_comb begin
        alu_op = alu_add;
        if (opcode == opc_op || opcode == opc_op_imm) begin
            case (funct3)
                3'b000:  alu_op = (opcode == opc_op && inst[30]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = inst[30] ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    assign is_store = (opcode == opc_store);
    assign is_mem   = (opcode == opc_load) || is_store;

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
/* Byte lane steering for a 32-bit data port with word-aligned addresses.
   Misaligned halfword and word accesses are not detected. */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic                    mem_issue,
    input  logic                    is_store,
    input  logic [2:0]              funct3,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] store_data,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic                    dmem_req,
    output logic                    dmem_we,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [3:0]              dmem_wstrb,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic [rv_pkg::xlen-1:0] load_data
);
    import rv_pkg::*;

    logic [xlen-1:0] rdata_shifted;

    assign dmem_req   = mem_issue;
    assign dmem_we    = mem_issue && is_store;
    assign dmem_addr  = {addr[xlen-1:2], 2'b00};
    assign dmem_wdata = store_data << {addr[1:0], 3'b000}; // move into the addressed lane

    always_comb begin
        case (funct3)
            f3_byte: dmem_wstrb = dmem_we ? (4'b0001 << addr[1:0]) : 4'b0000;
            f3_half: dmem_wstrb = dmem_we ? (4'b0011 << {addr[1], 1'b0}) : 4'b0000;
            f3_word: dmem_wstrb = {4{dmem_we}};
            default: dmem_wstrb = 4'b0000;
        endcase
    end

    // addressed byte or halfword lands in the low bits
    assign rdata_shifted = dmem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            f3_byte:   load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            f3_half:   load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            f3_byte_u: load_data = {24'h000000, rdata_shifted[7:0]};
            f3_half_u: load_data = {16'h0000, rdata_shifted[15:0]};
            default:   load_data = dmem_rdata; // lw
        endcase
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
/* 32 x 32 register file, combinational reads, one write per cycle.
   x0 stays zero only because the write enable is never raised for it. */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          reg_write,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]       wdata,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (reg_write) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- logic/rv_core.sv
/* Multi-cycle RV32I core, one instruction in flight, no CSRs or traps.
   Memories must answer one cycle after the request strobe and never stall. */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          imem_req,
    output logic [rv_pkg::xlen-1:0]       imem_addr,
    input  logic [rv_pkg::xlen-1:0]       imem_rdata,
    output logic                          dmem_req,
    output logic                          dmem_we,
    output logic [rv_pkg::xlen-1:0]       dmem_addr,
    output logic [3:0]                    dmem_wstrb,
    output logic [rv_pkg::xlen-1:0]       dmem_wdata,
    input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
    output logic                          retire_valid,
    output logic [rv_pkg::xlen-1:0]       retire_pc,
    output logic                          retire_rd_we,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_rd_data
);
    import rv_pkg::*;

    logic [xlen-1:0]       pc, inst, imm;
    logic [xlen-1:0]       rs1_data, rs2_data;
    logic [xlen-1:0]       alu_result, next_pc, wb_data, load_data;
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic [2:0]            funct3;
    opcode_t               opcode;
    alu_op_t               alu_op;
    logic                  is_mem, is_store, wb_we;
    logic                  mem_issue, reg_write;

    assign imem_addr = pc; // fetch address is the architectural pc

    core_control #(
        .reset_pc(reset_pc)
    ) u_control (
        .clk(clk), .reset(reset), .imem_rdata(imem_rdata), .is_mem(is_mem),
        .next_pc(next_pc), .wb_we(wb_we), .rd(rd), .wb_data(wb_data),
        .imem_req(imem_req), .pc(pc), .inst(inst), .mem_issue(mem_issue),
        .reg_write(reg_write), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd_we(retire_rd_we), .retire_rd(retire_rd), .retire_rd_data(retire_rd_data)
    );

    inst_decoder u_decoder (
        .inst(inst), .opcode(opcode), .funct3(funct3), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .alu_op(alu_op), .is_mem(is_mem), .is_store(is_store)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .reg_write(reg_write), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    exec_unit u_exec (
        .opcode(opcode), .funct3(funct3), .alu_op(alu_op), .pc(pc), .imm(imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .rd(rd), .load_data(load_data),
        .alu_result(alu_result), .next_pc(next_pc), .wb_we(wb_we), .wb_data(wb_data)
    );

    load_store_unit u_lsu (
        .mem_issue(mem_issue), .is_store(is_store), .funct3(funct3), .addr(alu_result),
        .store_data(rs2_data), .dmem_rdata(dmem_rdata), .dmem_req(dmem_req),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wstrb(dmem_wstrb),
        .dmem_wdata(dmem_wdata), .load_data(load_data)
    );

endmodule

`default_nettype wire

//--- logic/rv_pkg.sv
/* Shared widths, encodings and funct3 codes for the RV32I core.
   Only the RV32I base opcodes are listed; system and CSR opcodes are not decoded. */
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        st_fetch, st_decode, st_execute, st_mem
    } ctrl_state_t;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load / store sizes
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

endpackage

`default_nettype wire

//--- project.f
logic/rv_pkg.sv
logic/reg_file.sv
logic/inst_decoder.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/core_control.sv
logic/rv_core.sv
tests/rv_core_assert.sv
tests/rv_core_tb.sv

//--- tests/rv_core_assert.sv
/* Sequencing checks for core_control, bound into every instance of it. */
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input logic                clk,
    input logic                reset,
    input rv_pkg::ctrl_state_t state,
    input logic                imem_req,
    input logic                mem_issue,
    input logic                retire_valid
);
    import rv_pkg::*;

    int fail_count = 0; // read by the testbench summary

    // decode follows every fetch, so nothing fetches or retires there
    quiet_after_fetch: assert property (@(posedge clk) disable iff (reset)
        imem_req |=> !(imem_req || retire_valid))
        else begin
            $error("imem_req or retire_valid in the cycle after a fetch request");
            fail_count++;
        end

    mem_issue_in_execute: assert property (@(posedge clk) disable iff (reset)
        mem_issue |-> ($past(state) == st_decode))
        else begin
            $error("mem_issue raised in a cycle that does not follow decode");
            fail_count++;
        end

    mem_issue_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_issue |=> !mem_issue)
        else begin
            $error("mem_issue held longer than one cycle");
            fail_count++;
        end

    // next fetch right after the retire cycle
    fetch_after_retire: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> imem_req)
        else begin
            $error("no imem_req in the cycle after retire_valid");
            fail_count++;
        end

endmodule

bind core_control rv_core_assert u_core_assert (
    .clk(clk), .reset(reset), .state(state), .imem_req(imem_req),
    .mem_issue(mem_issue), .retire_valid(retire_valid)
);

`default_nettype wire

//--- tests/rv_core_tb.sv
/* Must be run from the project root so that the test data path resolves.
   Memory models hold 1 KB each and answer one cycle after a request. */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam logic [31:0] reset_pc  = 32'h0000_0000;
    localparam int          mem_words = 256;
    localparam int          max_exp   = 128;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata = '0;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_wstrb;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata = '0;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_rd_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_rd_data;

    logic [31:0] imem [mem_words];
    logic [31:0] dmem [mem_words];
    logic        imem_pend = 1'b0;
    logic [31:0] imem_pend_addr = '0;
    logic        dmem_pend = 1'b0;
    logic [31:0] dmem_pend_addr = '0;

    // expected retire trace
    logic [31:0] exp_pc  [max_exp];
    logic        exp_we  [max_exp];
    logic [4:0]  exp_rd  [max_exp];
    logic [31:0] exp_val [max_exp];

    // register values as the expected trace leaves them
    logic [31:0] shadow [32];

    int          n_exp, n_seen, errors, cycles, limit, req_cycle, assert_fails;
    int          errors_at_req;
    logic        req_is_mem, seen_req, timed_out;
    logic [31:0] req_inst;

    always #5 clk = ~clk;

    rv_core #(
        .reset_pc(reset_pc)
    ) UUT (
        .clk(clk), .reset(reset), .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_rdata(imem_rdata), .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wstrb(dmem_wstrb), .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd_we(retire_rd_we), .retire_rd(retire_rd), .retire_rd_data(retire_rd_data)
    );

    // requests taken at the rising edge, writes land there too
    always @(posedge clk) begin : mem_request
        logic [31:0] word;
        imem_pend      <= (imem_req === 1'b1);
        imem_pend_addr <= imem_addr;
        dmem_pend      <= (dmem_req === 1'b1) && (dmem_we !== 1'b1);
        dmem_pend_addr <= dmem_addr;
        if (dmem_req === 1'b1 && dmem_we === 1'b1) begin
            word = dmem[dmem_addr[9:2]];
            for (int b = 0; b < 4; b++) begin
                if (dmem_wstrb[b])
                    word[8*b +: 8] = dmem_wdata[8*b +: 8];
            end
            dmem[dmem_addr[9:2]] <= word;
        end
    end

    always @(negedge clk) begin // read data for the cycle after the request
        if (imem_pend)
            imem_rdata <= imem[imem_pend_addr[9:2]];
        if (dmem_pend)
            dmem_rdata <= dmem[dmem_pend_addr[9:2]];
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // load and store major opcodes take the extra mem cycle
    function automatic logic is_load_store(input logic [31:0] word);
        return (word[6:0] == 7'b0000011) || (word[6:0] == 7'b0100011);
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hd000_0000 | (i << 2);
        end
    endtask

    task automatic load_testdata();
        int               fd;
        int               code;
        logic [63:0]      tok;
        logic [31:0]      a, b, c, d;
        logic [8*128-1:0] rest;
        bit               at_end;
        at_end = 1'b0;
        fd = $fopen("tests/rv_core_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file tests/rv_core_testdata.txt");
            errors++;
        end else begin
            while (!at_end) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    at_end = 1'b1;
                end else if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "I") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    imem[a[9:2]] = b;
                end else if (tok == "D") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    dmem[a[9:2]] = b;
                end else if (tok == "E" && n_exp < max_exp) begin
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    exp_pc[n_exp]  = a;
                    exp_we[n_exp]  = b[0];
                    exp_rd[n_exp]  = c[4:0];
                    exp_val[n_exp] = d;
                    n_exp++;
                end else begin
                    $display("unreadable record in the test data file");
                    errors++;
                    at_end = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_reset_idle();
        if (imem_req === 1'b1 || dmem_req === 1'b1 || retire_valid === 1'b1) begin
            $display("request or retire seen during reset in cycle %0d", cycles);
            errors++;
        end
    endtask

    // data port request of the instruction in flight, from the ISA and the shadow registers
    task automatic check_mem_request();
        logic [31:0] offset;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] mask;
        logic [3:0]  strb;
        int          lane;
        int          size;
        if (!req_is_mem) begin
            $display("dmem_req raised for an instruction that is not a load or store");
            errors++;
        end else begin
            offset = {{20{req_inst[31]}}, req_inst[31:20]};
            if (req_inst[5])
                offset[4:0] = req_inst[11:7]; // store offset low bits sit in the rd field
            addr = shadow[req_inst[19:15]] + offset;
            lane = addr[1:0];
            size = 1 << req_inst[13:12]; // bytes
            strb = '0;
            mask = '0;
            data = '0;
            for (int b = 0; b < 4; b++) begin
                if (b >= lane && b < lane + size) begin
                    strb[b]        = 1'b1;
                    mask[8*b +: 8] = 8'hff;
                    data[8*b +: 8] = shadow[req_inst[24:20]][8*(b-lane) +: 8];
                end
            end
            compare_value("dmem_req latency", cycles - req_cycle + 1, 32'd3);
            compare_value("dmem_addr", dmem_addr, {addr[31:2], 2'b00});
            compare_value("dmem_we", 32'(dmem_we), 32'(req_inst[5]));
            if (req_inst[5]) begin
                compare_value("dmem_wstrb", 32'(dmem_wstrb), 32'(strb));
                compare_value("dmem_wdata", dmem_wdata & mask, data);
            end
        end
    endtask

    task automatic check_retire();
        logic [31:0] latency;
        latency = cycles - req_cycle + 1; // imem_req cycle through retire cycle
        compare_value("retire_pc", retire_pc, exp_pc[n_seen]);
        compare_value("retire_rd_we", 32'(retire_rd_we), 32'(exp_we[n_seen]));
        if (exp_we[n_seen]) begin
            compare_value("retire_rd", 32'(retire_rd), 32'(exp_rd[n_seen]));
            compare_value("retire_rd_data", retire_rd_data, exp_val[n_seen]);
            shadow[exp_rd[n_seen]] = exp_val[n_seen];
        end
        compare_value("retire latency", latency, req_is_mem ? 32'd4 : 32'd3);
        if (errors == errors_at_req)
            $display("test %0d at pc %h ok", n_seen, exp_pc[n_seen]);
        else
            $display("test %0d at pc %h wrong", n_seen, exp_pc[n_seen]);
        n_seen++;
    endtask

    initial begin
        n_exp         = 0;
        n_seen        = 0;
        errors        = 0;
        errors_at_req = 0;
        cycles        = 0;
        req_cycle     = 0;
        req_inst      = '0;
        req_is_mem    = 1'b0;
        seen_req      = 1'b0;
        timed_out     = 1'b0;
        for (int r = 0; r < 32; r++)
            shadow[r] = '0; // registers clear on reset
        fill_memories();
        load_testdata();
        if (n_exp == 0) begin
            $display("no expected retires found in the test data");
            errors++;
        end
        limit = n_exp * 4 + 50;

        repeat (8) begin
            @(posedge clk);
            cycles++;
            check_reset_idle();
        end
        @(negedge clk);
        reset = 1'b0;

        while (n_seen < n_exp && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (imem_req === 1'b1) begin
                errors_at_req = errors;
                if (!seen_req)
                    compare_value("imem_addr", imem_addr, reset_pc);
                seen_req   = 1'b1;
                req_cycle  = cycles;
                req_inst   = imem[imem_addr[9:2]];
                req_is_mem = is_load_store(req_inst);
            end
            if (dmem_req === 1'b1)
                check_mem_request();
            if (retire_valid === 1'b1)
                check_retire();
            if (cycles >= limit)
                timed_out = 1'b1;
        end

        if (timed_out) begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, n_seen, n_exp);
            errors++;
        end
        assert_fails = UUT.u_control.u_core_assert.fail_count;
        $display("%0d of %0d retires checked, %0d errors, %0d assertion failures",
                 n_seen, n_exp, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/rv_core_testdata.txt
# I addr word and D addr word fill instruction and data memory, all fields hex
# E pc rd_we rd value is the expected retire trace in order
D 100 11223344
D 104 55667788
D 108 99aabbcc
I 00 800000b7
E 00 1 01 80000000
I 04 ffb00113
E 04 1 02 fffffffb
I 08 00300193
E 08 1 03 00000003
I 0c 40218233
E 0c 1 04 00000008
I 10 4030d2b3
E 10 1 05 f0000000
I 14 0030d333
E 14 1 06 10000000
I 18 003123b3
E 18 1 07 00000001
I 1c 00313433
E 1c 1 08 00000000
I 20 40115493
E 20 1 09 fffffffd
I 24 fff1b513
E 24 1 0a 00000001
I 28 0ff14593
E 28 1 0b ffffff04
I 2c 00419613
E 2c 1 0c 00000030
I 30 00718013
E 30 0 00 00000000
I 34 003066b3
E 34 1 0d 00000003
I 38 0f017713
E 38 1 0e 000000f0
I 3c 12345797
E 3c 1 0f 1234503c
I 40 00318463
E 40 0 00 00000000
I 48 00319463
E 48 0 00 00000000
I 4c 00314463
E 4c 0 00 00000000
I 54 00315463
E 54 0 00 00000000
I 58 00316463
E 58 0 00 00000000
I 5c 00317463
E 5c 0 00 00000000
I 64 0080086f
E 64 1 10 00000068
I 6c 07d00893
E 6c 1 11 0000007d
I 70 00088967
E 70 1 12 00000074
I 7c 10000993
E 7c 1 13 00000100
I 80 00298023
E 80 0 00 00000000
I 84 003980a3
E 84 0 00 00000000
I 88 00b98123
E 88 0 00 00000000
I 8c 00e981a3
E 8c 0 00 00000000
I 90 00299223
E 90 0 00 00000000
I 94 00399523
E 94 0 00 00000000
I 98 0019a623
E 98 0 00 00000000
I 9c 0009aa03
E 9c 1 14 f00403fb
I a0 00398a83
E a0 1 15 fffffff0
I a4 0039cb03
E a4 1 16 000000f0
I a8 00198b83
E a8 1 17 00000003
I ac 00499c03
E ac 1 18 fffffffb
I b0 0049dc83
E b0 1 19 0000fffb
I b4 00a99d03
E b4 1 1a 00000003
I b8 0089ad83
E b8 1 1b 0003bbcc
I bc 00c9ae03
E bc 1 1c 80000000
I c0 0089de83
E c0 1 1d 0000bbcc
I c4 0069cf03
E c4 1 1e 00000066
I c8 0000006f
E c8 0 00 00000000
